// ==== include/loader_config.svh ====
/* Loader constants shared by RTL and testbench
   Cartridge base must stay inside the SDRAM byte address range */
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// ==============================
// Host file indices
// ==============================

// Boot ROM image
`define LOADER_INDEX_PIFROM 0
// Cartridge image
`define LOADER_INDEX_CART 1
// Only the low index bits are decoded
`define LOADER_INDEX_BITS 6

// ==============================
// Address layout
// ==============================

`define LOADER_ADDR_BITS 27
`define LOADER_PIFROM_ADDR_BITS 9
// Cartridge image sits at 8 MB in SDRAM
`define LOADER_CART_BASE 8388608

`endif

// ==== rtl/loader_pkg.sv ====
/* Types for the loader pipeline
   Address widths come from the loader config header */
`default_nettype none

`include "loader_config.svh"

package loader_pkg;

	// ==============================
	// Payload types
	// ==============================

	// Host byte address or mapped write address
	typedef logic [`LOADER_ADDR_BITS-1:0] load_addr_t;

	typedef logic [31:0] load_word_t;

	typedef logic [15:0] half_word_t;

	// ==============================
	// Enums
	// ==============================

	// Where a finished word is written
	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_PIFROM,
		TGT_CART
	} load_target_t;

	typedef enum logic [0:0] {
		DSP_IDLE,
		DSP_SDRAM_WAIT
	} dispatch_state_t;

endpackage

`default_nettype wire

// ==== rtl/load_word_if.sv ====
/* One word between loader stages, valid/ready handshake
   Source holds valid and payload steady until ready is seen */
`timescale 1ns/10ps
`default_nettype none

interface load_word_if
	import loader_pkg::*;
();

	logic         valid;
	logic         ready;
	load_target_t target;
	load_addr_t   addr;
	load_word_t   data;

	// Producer side
	modport src (
		output valid, target, addr, data,
		input  ready
	);

	// Consumer side
	modport dst (
		input  valid, target, addr, data,
		output ready
	);

endinterface

`default_nettype wire

// ==== rtl/ioctl_word_assembler.sv ====
/* Pairs host halfwords into words, low half (addr bit 1 clear) first
   Host must not pulse ioctl_wr while ioctl_wait is high */
`timescale 1ns/10ps
`default_nettype none

`include "loader_config.svh"

module ioctl_word_assembler
	import loader_pkg::*;
(
	input  wire              clk_1x,
	input  wire              reset,
	input  wire              ioctl_download,
	input  wire [7:0]        ioctl_index,
	input  wire load_addr_t  ioctl_addr,
	input  wire half_word_t  ioctl_dout,
	input  wire              ioctl_wr,
	output logic             ioctl_wait,
	output logic             cart_download,
	output logic             cart_loaded,
	load_word_if.src         out_word
);

	load_target_t index_target;
	load_target_t target_q;
	half_word_t   first_data;
	load_addr_t   first_addr;
	logic         word_pending;
	load_target_t word_target;
	load_addr_t   word_addr;
	load_word_t   word_data;
	logic         write_hit;
	logic         out_taken;

	// ==============================
	// Download target decode
	// ==============================

	always_comb begin
		index_target = TGT_NONE;
		if (ioctl_download) begin
			if (ioctl_index[`LOADER_INDEX_BITS-1:0] ==
					`LOADER_INDEX_BITS'(`LOADER_INDEX_PIFROM))
				index_target = TGT_PIFROM;
			else if (ioctl_index[`LOADER_INDEX_BITS-1:0] ==
					`LOADER_INDEX_BITS'(`LOADER_INDEX_CART))
				index_target = TGT_CART;
		end
	end

	// Decode lags ioctl_download by one cycle
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			target_q    <= TGT_NONE;
			cart_loaded <= 1'b0;
		end else begin
			target_q <= index_target;
			// Sticky until reset
			if (target_q == TGT_CART)
				cart_loaded <= 1'b1;
		end
	end

	assign cart_download = (target_q == TGT_CART);

	// ==============================
	// Halfword pairing
	// ==============================

	// Writes for unknown indices are dropped here
	assign write_hit = ioctl_wr && (target_q != TGT_NONE);
	assign out_taken = word_pending && out_word.ready;

	always_ff @(posedge clk_1x) begin
		if (reset)
			word_pending <= 1'b0;
		else if (write_hit && ioctl_addr[1])
			word_pending <= 1'b1;
		else if (out_taken)
			word_pending <= 1'b0;
	end

	always_ff @(posedge clk_1x) begin
		if (write_hit && !ioctl_addr[1]) begin
			first_data <= ioctl_dout;
			first_addr <= ioctl_addr;
		end
		// Lone second half reuses the last stored first half
		if (write_hit && ioctl_addr[1]) begin
			word_target <= target_q;
			word_addr   <= first_addr;
			word_data   <= {ioctl_dout, first_data};
		end
	end

	assign out_word.valid  = word_pending;
	assign out_word.target = word_target;
	assign out_word.addr   = word_addr;
	assign out_word.data   = word_data;

	// Stall host while the output word is held
	assign ioctl_wait = word_pending;

	host_honors_wait_a: assert property (@(posedge clk_1x) disable iff (reset)
		ioctl_wait |-> !ioctl_wr);

endmodule

`default_nettype wire

// ==== rtl/load_address_mapper.sv ====
/* One-entry pipeline stage that applies each target's byte order and address rule
   Boot ROM address is the word index and cartridge address is offset by the base */
`timescale 1ns/10ps
`default_nettype none

`include "loader_config.svh"

module load_address_mapper
	import loader_pkg::*;
(
	input  wire       clk_1x,
	input  wire       reset,
	load_word_if.dst  in_word,
	load_word_if.src  out_word
);

	logic         valid_q;
	load_target_t target_q;
	load_addr_t   addr_q;
	load_word_t   data_q;
	load_addr_t   mapped_addr;
	load_word_t   mapped_data;
	logic         in_fire;
	logic         out_fire;

	assign out_fire      = valid_q && out_word.ready;
	assign in_word.ready = !valid_q || out_word.ready;
	assign in_fire       = in_word.valid && in_word.ready;

	// ==============================
	// Mapping rules
	// ==============================

	always_comb begin
		mapped_addr = in_word.addr;
		mapped_data = in_word.data;
		case (in_word.target)
			TGT_PIFROM: begin
				mapped_addr = load_addr_t'(in_word.addr[`LOADER_PIFROM_ADDR_BITS+1:2]);
				// Byte swap inside each halfword
				mapped_data = {in_word.data[23:16], in_word.data[31:24],
					in_word.data[7:0], in_word.data[15:8]};
			end
			TGT_CART: begin
				mapped_addr = in_word.addr + load_addr_t'(`LOADER_CART_BASE);
			end
			default: begin
				mapped_addr = in_word.addr;
			end
		endcase
	end

	// ==============================
	// Pipeline register
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (reset)
			valid_q <= 1'b0;
		else if (in_fire)
			valid_q <= 1'b1;
		else if (out_fire)
			valid_q <= 1'b0;
	end

	always_ff @(posedge clk_1x) begin
		if (in_fire) begin
			target_q <= in_word.target;
			addr_q   <= mapped_addr;
			data_q   <= mapped_data;
		end
	end

	assign out_word.valid  = valid_q;
	assign out_word.target = target_q;
	assign out_word.addr   = addr_q;
	assign out_word.data   = data_q;

	// Upstream word must hold steady until this stage takes it
	stall_holds_payload_a: assert property (@(posedge clk_1x) disable iff (reset)
		in_word.valid && !in_word.ready |=> in_word.valid && $stable(in_word.target)
			&& $stable(in_word.addr) && $stable(in_word.data));

endmodule

`default_nettype wire

// ==== rtl/memory_write_dispatch.sv ====
/* Writes mapped words to the boot ROM port or the SDRAM channel
   One SDRAM write outstanding, sdram_ready must come at least a cycle after sdram_req */
`timescale 1ns/10ps
`default_nettype none

`include "loader_config.svh"

module memory_write_dispatch
	import loader_pkg::*;
(
	input  wire                                  clk_1x,
	input  wire                                  reset,
	load_word_if.dst                             in_word,
	output logic                                 pifrom_wren,
	output logic [`LOADER_PIFROM_ADDR_BITS-1:0]  pifrom_wraddress,
	output load_word_t                           pifrom_wrdata,
	output logic                                 sdram_req,
	output load_addr_t                           sdram_addr,
	output load_word_t                           sdram_data,
	input  wire                                  sdram_ready
);

	dispatch_state_t state;
	logic            accept;
	logic            accept_pifrom;
	logic            accept_cart;

	// Boot ROM never stalls, so only an SDRAM write blocks input
	assign in_word.ready = (state == DSP_IDLE);
	assign accept        = in_word.valid && in_word.ready;
	assign accept_pifrom = accept && (in_word.target == TGT_PIFROM);
	assign accept_cart   = accept && (in_word.target == TGT_CART);

	// ==============================
	// Control
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			state       <= DSP_IDLE;
			pifrom_wren <= 1'b0;
			sdram_req   <= 1'b0;
		end else begin
			// Both strobes are single-cycle pulses
			pifrom_wren <= accept_pifrom;
			sdram_req   <= accept_cart;
			case (state)
				DSP_IDLE: begin
					if (accept_cart)
						state <= DSP_SDRAM_WAIT;
				end
				DSP_SDRAM_WAIT: begin
					if (sdram_ready)
						state <= DSP_IDLE;
				end
				default: begin
					state <= DSP_IDLE;
				end
			endcase
		end
	end

	// ==============================
	// Write payload
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (accept_pifrom) begin
			pifrom_wraddress <= in_word.addr[`LOADER_PIFROM_ADDR_BITS-1:0];
			pifrom_wrdata    <= in_word.data;
		end
		// Held through the wait state
		if (accept_cart) begin
			sdram_addr <= in_word.addr;
			sdram_data <= in_word.data;
		end
	end

	// New request only ever leaves the idle state
	req_from_idle_a: assert property (@(posedge clk_1x) disable iff (reset)
		sdram_req |-> $past(state) == DSP_IDLE);

	// Ready must close an outstanding write, never the request cycle itself
	ready_in_wait_a: assert property (@(posedge clk_1x) disable iff (reset)
		sdram_ready |-> state == DSP_SDRAM_WAIT && !sdram_req);

endmodule

`default_nettype wire

// ==== rtl/rom_loader_top.sv ====
/* Boot ROM and cartridge loader, assembler then mapper then dispatch
   Empty pipeline latency is 3 cycles from second halfword to write strobe */
`timescale 1ns/10ps
`default_nettype none

`include "loader_config.svh"

module rom_loader_top
	import loader_pkg::*;
(
	input  wire                                  clk_1x,
	input  wire                                  reset,
	// Host loader
	input  wire                                  ioctl_download,
	input  wire [7:0]                            ioctl_index,
	input  wire load_addr_t                      ioctl_addr,
	input  wire half_word_t                      ioctl_dout,
	input  wire                                  ioctl_wr,
	output logic                                 ioctl_wait,
	// Boot ROM write port
	output logic                                 pifrom_wren,
	output logic [`LOADER_PIFROM_ADDR_BITS-1:0]  pifrom_wraddress,
	output load_word_t                           pifrom_wrdata,
	// SDRAM write channel
	output logic                                 sdram_req,
	output load_addr_t                           sdram_addr,
	output load_word_t                           sdram_data,
	input  wire                                  sdram_ready,
	// Status
	output logic                                 cart_download,
	output logic                                 cart_loaded
);

	load_word_if asm_to_map ();
	load_word_if map_to_dsp ();

	ioctl_word_assembler i_assembler (
		.clk_1x         (clk_1x),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.ioctl_wait     (ioctl_wait),
		.cart_download  (cart_download),
		.cart_loaded    (cart_loaded),
		.out_word       (asm_to_map.src)
	);

	load_address_mapper i_mapper (
		.clk_1x   (clk_1x),
		.reset    (reset),
		.in_word  (asm_to_map.dst),
		.out_word (map_to_dsp.src)
	);

	memory_write_dispatch i_dispatch (
		.clk_1x           (clk_1x),
		.reset            (reset),
		.in_word          (map_to_dsp.dst),
		.pifrom_wren      (pifrom_wren),
		.pifrom_wraddress (pifrom_wraddress),
		.pifrom_wrdata    (pifrom_wrdata),
		.sdram_req        (sdram_req),
		.sdram_addr       (sdram_addr),
		.sdram_data       (sdram_data),
		.sdram_ready      (sdram_ready)
	);

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
/* Testbench clock and reset, 10 ns period
   Reset is high for 5 rising edges and drops on a falling edge */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int RESET_CYCLES = 5
) (
	output logic clk_1x,
	output logic reset
);

	initial begin
		clk_1x = 1'b0;
		forever #5 clk_1x = ~clk_1x;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_1x);
		@(negedge clk_1x);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== test/rom_loader_tb.sv ====
/* Directed tests for the loader with inputs driven on the falling edge
   SDRAM responder answers after 1 to 8 cycles using seeded $random */
`timescale 1ns/10ps
`default_nettype none

`include "loader_config.svh"

module rom_loader_tb
	import loader_pkg::*;
();

	// Boot 16 words plus unused index 4 plus cartridge 24
	localparam int TOTAL_WORDS     = 44;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 300;
	localparam int DRAIN_LIMIT     = 400;

	logic        clk_1x;
	logic        reset;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	load_addr_t  ioctl_addr;
	half_word_t  ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;
	logic        pifrom_wren;
	logic [`LOADER_PIFROM_ADDR_BITS-1:0] pifrom_wraddress;
	load_word_t  pifrom_wrdata;
	logic        sdram_req;
	load_addr_t  sdram_addr;
	load_word_t  sdram_data;
	logic        sdram_ready;
	logic        cart_download;
	logic        cart_loaded;

	integer      seed = 59;
	int          check_count = 0;
	int          error_count = 0;

	// Observed and expected writes with addresses zero-extended
	logic [31:0] pif_addr_q[$];
	logic [31:0] pif_data_q[$];
	logic [31:0] sdram_addr_q[$];
	logic [31:0] sdram_data_q[$];
	logic [31:0] exp_pif_addr_q[$];
	logic [31:0] exp_pif_data_q[$];
	logic [31:0] exp_sdram_addr_q[$];
	logic [31:0] exp_sdram_data_q[$];

	tb_clock_gen i_clock_gen (
		.clk_1x (clk_1x),
		.reset  (reset)
	);

	rom_loader_top i_dut (
		.clk_1x           (clk_1x),
		.reset            (reset),
		.ioctl_download   (ioctl_download),
		.ioctl_index      (ioctl_index),
		.ioctl_addr       (ioctl_addr),
		.ioctl_dout       (ioctl_dout),
		.ioctl_wr         (ioctl_wr),
		.ioctl_wait       (ioctl_wait),
		.pifrom_wren      (pifrom_wren),
		.pifrom_wraddress (pifrom_wraddress),
		.pifrom_wrdata    (pifrom_wrdata),
		.sdram_req        (sdram_req),
		.sdram_addr       (sdram_addr),
		.sdram_data       (sdram_data),
		.sdram_ready      (sdram_ready),
		.cart_download    (cart_download),
		.cart_loaded      (cart_loaded)
	);

	// ==============================
	// Checks
	// ==============================

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		assert (actual === expected) else begin
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_true(input logic condition, input string what);
		check_count++;
		assert (condition === 1'b1) else begin
			$display("Error: %s", what);
			error_count++;
		end
	endtask

	function automatic half_word_t swap_bytes(input half_word_t value);
		return {value[7:0], value[15:8]};
	endfunction

	// ==============================
	// Host and SDRAM models
	// ==============================

	task automatic write_halfword(input load_addr_t addr, input half_word_t data);
		while (ioctl_wait)
			@(negedge clk_1x);
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_1x);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_1x);
	endtask

	// Sends words and records what each target should see
	task automatic send_words(input load_addr_t start, input int count,
			input load_target_t tgt);
		logic [31:0] rnd;
		load_addr_t  byte_addr;
		for (int i = 0; i < count; i++) begin
			rnd       = $random(seed);
			byte_addr = start + load_addr_t'(4 * i);
			write_halfword(byte_addr, rnd[15:0]);
			write_halfword(byte_addr + load_addr_t'(2), rnd[31:16]);
			if (tgt == TGT_PIFROM) begin
				exp_pif_addr_q.push_back(32'(byte_addr >> 2) & 32'h1ff);
				exp_pif_data_q.push_back({swap_bytes(rnd[31:16]), swap_bytes(rnd[15:0])});
			end else if (tgt == TGT_CART) begin
				exp_sdram_addr_q.push_back(32'(byte_addr + load_addr_t'(`LOADER_CART_BASE)));
				exp_sdram_data_q.push_back(rnd);
			end
		end
	endtask

	// Waits for the expected counts and then idles to catch extra writes
	task automatic wait_for_writes(input int pif_count, input int sdram_count);
		int cycles;
		cycles = 0;
		while ((pif_addr_q.size() < pif_count || sdram_addr_q.size() < sdram_count)
				&& cycles < DRAIN_LIMIT) begin
			@(negedge clk_1x);
			cycles++;
		end
		check_true(cycles < DRAIN_LIMIT, "expected writes did not arrive in time");
		repeat (12) @(negedge clk_1x);
	endtask

	task automatic compare_writes();
		check_value("pifrom write count", pif_addr_q.size(), exp_pif_addr_q.size());
		check_value("sdram write count", sdram_addr_q.size(), exp_sdram_addr_q.size());
		for (int i = 0; i < pif_addr_q.size() && i < exp_pif_addr_q.size(); i++) begin
			check_value("pifrom_wraddress", pif_addr_q[i], exp_pif_addr_q[i]);
			check_value("pifrom_wrdata", pif_data_q[i], exp_pif_data_q[i]);
		end
		for (int i = 0; i < sdram_addr_q.size() && i < exp_sdram_addr_q.size(); i++) begin
			check_value("sdram_addr", sdram_addr_q[i], exp_sdram_addr_q[i]);
			check_value("sdram_data", sdram_data_q[i], exp_sdram_data_q[i]);
		end
		pif_addr_q.delete();
		pif_data_q.delete();
		sdram_addr_q.delete();
		sdram_data_q.delete();
		exp_pif_addr_q.delete();
		exp_pif_data_q.delete();
		exp_sdram_addr_q.delete();
		exp_sdram_data_q.delete();
	endtask

	// Write strobes are one-cycle pulses, so each low edge sees one write
	always @(negedge clk_1x) begin
		if (!reset) begin
			if (pifrom_wren) begin
				pif_addr_q.push_back(32'(pifrom_wraddress));
				pif_data_q.push_back(pifrom_wrdata);
			end
			if (sdram_req) begin
				sdram_addr_q.push_back(32'(sdram_addr));
				sdram_data_q.push_back(sdram_data);
			end
		end
	end

	// SDRAM responder answers each request after 1 to 8 cycles
	initial begin
		int delay;
		sdram_ready = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (sdram_req) begin
				delay = ($random(seed) & 7) + 1;
				repeat (delay) @(negedge clk_1x);
				sdram_ready = 1'b1;
				@(negedge clk_1x);
				sdram_ready = 1'b0;
			end
		end
	end

	// ==============================
	// Tests
	// ==============================

	task automatic test_reset_state();
		check_value("ioctl_wait", ioctl_wait, 0);
		check_value("pifrom_wren", pifrom_wren, 0);
		check_value("sdram_req", sdram_req, 0);
		check_value("cart_download", cart_download, 0);
		check_value("cart_loaded", cart_loaded, 0);
	endtask

	task automatic test_boot_rom();
		start_download(8'(`LOADER_INDEX_PIFROM));
		check_value("cart_download", cart_download, 0);
		send_words('0, 16, TGT_PIFROM);
		wait_for_writes(16, 0);
		end_download();
		compare_writes();
		check_value("cart_loaded", cart_loaded, 0);
	endtask

	task automatic test_cartridge();
		start_download(8'(`LOADER_INDEX_CART));
		check_value("cart_download", cart_download, 1);
		check_value("cart_loaded", cart_loaded, 1);
		send_words(load_addr_t'(32'h1000), 24, TGT_CART);
		wait_for_writes(0, 24);
		check_value("cart_download", cart_download, 1);
		end_download();
		check_value("cart_download", cart_download, 0);
		check_value("cart_loaded", cart_loaded, 1);
		compare_writes();
	endtask

	// Runs before any cartridge load so cart_loaded is still clear
	task automatic test_unused_index();
		start_download(8'd5);
		check_value("cart_download", cart_download, 0);
		send_words(load_addr_t'(32'h200), 4, TGT_NONE);
		repeat (20) @(negedge clk_1x);
		end_download();
		compare_writes();
		check_value("cart_loaded", cart_loaded, 0);
	endtask

	// ==============================
	// Run control
	// ==============================

	initial begin
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		@(negedge reset);
		@(negedge clk_1x);
		test_reset_state();
		test_boot_rom();
		test_unused_index();
		test_cartridge();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_1x);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
rtl/loader_pkg.sv
rtl/load_word_if.sv
rtl/ioctl_word_assembler.sv
rtl/load_address_mapper.sv
rtl/memory_write_dispatch.sv
rtl/rom_loader_top.sv
test/tb_clock_gen.sv
test/rom_loader_tb.sv
